// ==== hdl/credit_output_stage.sv ====
/*
 Two-entry output buffer with a downstream credit counter.
 The sender upstream must honour slot_free, which already counts the
 packet leaving this cycle. Credits saturate at the top of COUNT_W.
*/
`default_nettype none

module credit_output_stage
    import merge_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  merged_packet_t packet_in,
    output logic           slot_free,
    input  logic           out_credit,
    output merged_packet_t packet_out,
    output logic           last_sent
);

    merged_packet_t     slot [2];
    logic [1:0]         fill;
    logic [1:0]         occupancy;
    logic [COUNT_W-1:0] credits;
    logic               push;
    logic               send;
    logic               out_valid;
    merged_packet_t     out_payload;

    assign push      = packet_in.valid;
    assign send      = (fill != 2'd0) && (credits != '0);
    assign occupancy = fill + 2'(push) - 2'(send);
    assign slot_free = (occupancy < 2'd2);

    // ----------------------------------------------------------------------
    // Buffer slots with slot[0] as the head
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (send) begin
            out_payload <= slot[0];
            slot[0]     <= (push && (fill == 2'd1)) ? packet_in : slot[1];
            if (push && (fill == 2'd2)) begin
                slot[1] <= packet_in;
            end
        end else if (push) begin
            if (fill == 2'd0) begin
                slot[0] <= packet_in;
            end else begin
                slot[1] <= packet_in;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            fill      <= 2'd0;
            credits   <= '0;
            out_valid <= 1'b0;
            last_sent <= 1'b0;
        end else begin
            fill      <= fill + 2'(push) - 2'(send);
            out_valid <= send;
            last_sent <= send && slot[0].last;
            // Grant and send in one cycle cancel out
            case ({out_credit, send})
                2'b10:   credits <= (credits == '1) ? credits : credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_comb begin
        packet_out       = out_payload;
        packet_out.valid = out_valid;
    end

    // A packet leaves only on a credit that was held or had just arrived
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        packet_out.valid |-> (($past(credits, 2) != '0) || $past(out_credit, 2)));

    // Upstream must keep to slot_free and never overrun the buffer
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        push |-> ((fill != 2'd2) || send));

endmodule

`default_nettype wire

// ==== hdl/lane_fifo.sv ====
/*
 Synchronous FIFO with first-word-fall-through head.
 Writers must track free space with the credit pulses; a push into
 a full FIFO is dropped. One credit pulse follows every pop by a cycle.
*/
`default_nettype none

module lane_fifo
    import merge_pkg::*;
#(
    parameter int  DEPTH     = 8,
    parameter type payload_t = lane_word_t
) (
    input  logic     ap_clk,
    input  logic     areset_generator,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    // Wraps at DEPTH, so depths need not be powers of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;
    assign head      = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= do_pop;
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Writer ran past its credits
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        push |-> !full);

    // Reader took a word that was never there
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        pop |-> not_empty);

endmodule

`default_nettype wire

// ==== hdl/merge_data_generator.sv ====
/*
 Merge data generator for one lane group.
 All inputs pass one register stage before their FIFOs. The host gets
 one configuration credit after reset and one per accepted job.
 Each lane sender starts with LANE_FIFO_DEPTH credits.
*/
`default_nettype none

module merge_data_generator
    import merge_pkg::*;
#(
    parameter int LANES           = 4,
    parameter int LANE_FIFO_DEPTH = 8
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  merge_config_t    config_in,
    output logic             config_credit,
    input  lane_word_t       lane_in [LANES],
    output logic [LANES-1:0] lane_credit,
    output merged_packet_t   packet_out,
    input  logic             out_credit,
    output logic             done
);

    if (LANES < 1 || LANES > MAX_LANES) begin : g_lanes_check
        $error("LANES must lie between 1 and MAX_LANES");
    end

    merge_config_t    config_q;
    logic             config_push;
    merge_config_t    cfg_head;
    logic             cfg_ready;
    logic             cfg_pop;
    logic             cfg_credit;
    logic             primed;
    lane_word_t       lane_q [LANES];
    logic [LANES-1:0] lane_push;
    lane_word_t       lane_head [LANES];
    logic [LANES-1:0] lane_ready;
    logic [LANES-1:0] lane_pop;
    logic             out_credit_q;
    merged_packet_t   packet_int;
    logic             slot_free;
    logic             last_sent;

    // ----------------------------------------------------------------------
    // Input registers
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        config_q <= config_in;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            config_push   <= 1'b0;
            out_credit_q  <= 1'b0;
            primed        <= 1'b0;
            config_credit <= 1'b0;
        end else begin
            config_push   <= config_in.valid;
            out_credit_q  <= out_credit;
            primed        <= 1'b1;
            // Initial host credit on the first cycle out of reset
            config_credit <= cfg_credit || !primed;
        end
    end

    lane_fifo #(
        .DEPTH     (2),
        .payload_t (merge_config_t)
    ) u_config_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (config_push),
        .push_data        (config_q),
        .pop              (cfg_pop),
        .head             (cfg_head),
        .not_empty        (cfg_ready),
        .credit           (cfg_credit)
    );

    // ----------------------------------------------------------------------
    // Lane side
    // ----------------------------------------------------------------------
    for (genvar l = 0; l < LANES; l++) begin : g_lane
        always_ff @(posedge ap_clk) begin
            lane_q[l] <= lane_in[l];
        end

        always_ff @(posedge ap_clk) begin
            if (areset_generator) begin
                lane_push[l] <= 1'b0;
            end else begin
                lane_push[l] <= lane_in[l].valid;
            end
        end

        lane_fifo #(
            .DEPTH     (LANE_FIFO_DEPTH),
            .payload_t (lane_word_t)
        ) u_lane_fifo (
            .ap_clk           (ap_clk),
            .areset_generator (areset_generator),
            .push             (lane_push[l]),
            .push_data        (lane_q[l]),
            .pop              (lane_pop[l]),
            .head             (lane_head[l]),
            .not_empty        (lane_ready[l]),
            .credit           (lane_credit[l])
        );
    end

    merge_sequencer #(
        .LANES (LANES)
    ) u_sequencer (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg              (cfg_head),
        .cfg_ready        (cfg_ready),
        .cfg_pop          (cfg_pop),
        .lane_head        (lane_head),
        .lane_ready       (lane_ready),
        .lane_pop         (lane_pop),
        .packet           (packet_int),
        .slot_free        (slot_free),
        .last_sent        (last_sent),
        .done             (done)
    );

    credit_output_stage u_output_stage (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .packet_in        (packet_int),
        .slot_free        (slot_free),
        .out_credit       (out_credit_q),
        .packet_out       (packet_out),
        .last_sent        (last_sent)
    );

endmodule

`default_nettype wire

// ==== hdl/merge_pkg.sv ====
/*
 Widths and payload types shared by the merge data generator.
 The lane count of a build must not exceed MAX_LANES. Lane slots
 of a merged packet above the active lane count always read zero.
*/
`default_nettype none

package merge_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int LANE_DATA_W = 16;
    localparam int COUNT_W     = 16;
    localparam int MAX_LANES   = 8;

    // ----------------------------------------------------------------------
    // Payload types
    // ----------------------------------------------------------------------

    // One word from a response lane
    typedef struct packed {
        logic                   valid;
        logic [LANE_DATA_W-1:0] data;
    } lane_word_t;

    // Job configuration, one word starts one job
    typedef struct packed {
        logic               valid;
        logic [COUNT_W-1:0] packet_count;
    } merge_config_t;

    // Lane 0 sits in lane_data[0]
    typedef struct packed {
        logic                                  valid;
        logic [COUNT_W-1:0]                    index;
        logic                                  last;
        logic [MAX_LANES-1:0][LANE_DATA_W-1:0] lane_data;
    } merged_packet_t;

    // ----------------------------------------------------------------------
    // Sequencer phases
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        SETUP = 3'd1,
        BUSY  = 3'd2,
        PAUSE = 3'd3,
        DONE  = 3'd4
    } merge_state_t;

endpackage

`default_nettype wire

// ==== hdl/merge_sequencer.sv ====
/*
 Job FSM: takes one configuration, then merges one word from every
 lane into each packet until the count is used up.
 Packets are emitted only while the output stage reports a free slot.
 done rises after the final packet has left and clears on the next job.
*/
`default_nettype none

module merge_sequencer
    import merge_pkg::*;
#(
    parameter int LANES = 4
) (
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  merge_config_t  cfg,
    input  logic           cfg_ready,
    output logic           cfg_pop,
    input  lane_word_t     lane_head [LANES],
    input  logic [LANES-1:0] lane_ready,
    output logic [LANES-1:0] lane_pop,
    output merged_packet_t packet,
    input  logic           slot_free,
    input  logic           last_sent,
    output logic           done
);

    merge_state_t                          state;
    logic [COUNT_W-1:0]                    remaining;
    logic [COUNT_W-1:0]                    index;
    logic [MAX_LANES-1:0][LANE_DATA_W-1:0] merged_lanes;
    logic                                  take_cfg;
    logic                                  merge_now;
    logic                                  final_packet;
    logic                                  heads_valid;
    logic                                  pkt_valid;
    merged_packet_t                        pkt_payload;

    // ----------------------------------------------------------------------
    // Pop decisions
    // ----------------------------------------------------------------------
    assign take_cfg     = (state == IDLE) && cfg_ready;
    assign merge_now    = (state == BUSY) && (&lane_ready) && slot_free;
    assign final_packet = (remaining == COUNT_W'(1));
    assign cfg_pop      = take_cfg;
    assign lane_pop     = {LANES{merge_now}};

    // Inactive lane slots stay zero
    always_comb begin
        merged_lanes = '0;
        heads_valid  = 1'b1;
        for (int l = 0; l < LANES; l++) begin
            merged_lanes[l] = lane_head[l].data;
            heads_valid     = heads_valid && lane_head[l].valid;
        end
    end

    // ----------------------------------------------------------------------
    // Phase control
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state     <= IDLE;
            remaining <= '0;
            index     <= '0;
            pkt_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            pkt_valid <= merge_now;
            if (take_cfg) begin
                remaining <= cfg.packet_count;
                index     <= '0;
                done      <= 1'b0;
            end else if (merge_now) begin
                remaining <= remaining - 1'b1;
                index     <= index + 1'b1;
            end
            case (state)
                IDLE: begin
                    if (take_cfg) begin
                        state <= SETUP;
                    end
                end
                SETUP: begin
                    // Empty job skips straight to completion
                    state <= (remaining == '0) ? DONE : BUSY;
                end
                BUSY: begin
                    if (merge_now && final_packet) begin
                        state <= DONE;
                    end else if (!slot_free) begin
                        state <= PAUSE;
                    end
                end
                PAUSE: begin
                    if (slot_free) begin
                        state <= BUSY;
                    end
                end
                DONE: begin
                    // index stays zero only for a job without packets
                    if (last_sent || (index == '0)) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Packet build
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (merge_now) begin
            pkt_payload <= '{valid: 1'b1, index: index, last: final_packet,
                             lane_data: merged_lanes};
        end
    end

    always_comb begin
        packet       = pkt_payload;
        packet.valid = pkt_valid;
    end

    // All lanes advance together and only over words actually stored
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        (|lane_pop) |-> ((&lane_pop) && heads_valid));

endmodule

`default_nettype wire

// ==== merge_data_generator.f ====
hdl/merge_pkg.sv
hdl/lane_fifo.sv
hdl/merge_sequencer.sv
hdl/credit_output_stage.sv
hdl/merge_data_generator.sv
verification/merge_data_generator_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the merge data generator testbench with Verilator and runs it.
# Exit status is nonzero on a build error, a simulator error or a failed check.

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module merge_data_generator_tb \
    -f merge_data_generator.f \
    -o merge_data_generator_sim \
    && ./obj_dir/merge_data_generator_sim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat "$LOG"

grep -q "Verification failed" "$LOG" && exit 1 || exit 0

// ==== verification/merge_data_generator_tb.sv ====
/*
 Testbench for the merge data generator, four lanes of depth eight.
 Jobs come from a table; lane words are computed from the job seed,
 the packet index and the lane, so every packet can be predicted.
 Output credits follow the job's pattern: steady, sparse or held off.
*/
`default_nettype none

module merge_data_generator_tb
    import merge_pkg::*;
();

    localparam int LANES            = 4;
    localparam int FIFO_DEPTH       = 8;
    localparam int CLK_PERIOD       = 20;
    localparam int NUM_JOBS         = 6;
    localparam int HOLD_CYCLES      = 40;
    localparam int CYCLES_PER_PKT   = 40;
    localparam int CYCLES_PER_JOB   = 60;
    localparam int RESPONSE_CYCLES  = 20;

    typedef enum logic [1:0] {
        STEADY = 2'd0,
        SPARSE = 2'd1,
        HELD   = 2'd2
    } credit_mode_t;

    typedef struct packed {
        logic [COUNT_W-1:0]     count;
        logic [LANE_DATA_W-1:0] seed;
        credit_mode_t           mode;
    } job_t;

    logic             ap_clk = 1'b0;
    logic             areset_generator;
    merge_config_t    config_in;
    logic             config_credit;
    lane_word_t       lane_in [LANES];
    logic [LANES-1:0] lane_credit;
    merged_packet_t   packet_out;
    logic             out_credit;
    logic             done;

    job_t jobs [NUM_JOBS];
    int   seed            = 32'hede4;
    int   errors          = 0;
    int   checks          = 0;
    int   words_requested = 0;
    int   packets_seen    = 0;
    int   grants_total    = 0;
    int   valid_pulses;
    int   config_pulses;
    int   cycle;
    int   words_sent    [LANES];
    int   sender_credits[LANES];
    int   credit_pulses [LANES];

    merge_data_generator #(
        .LANES           (LANES),
        .LANE_FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .config_in        (config_in),
        .config_credit    (config_credit),
        .lane_in          (lane_in),
        .lane_credit      (lane_credit),
        .packet_out       (packet_out),
        .out_credit       (out_credit),
        .done             (done)
    );

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    // ----------------------------------------------------------------------
    // Job table and reference model
    // ----------------------------------------------------------------------
    task automatic load_job_table();
        jobs[0] = '{count: 16'd5,  seed: 16'h3c01, mode: STEADY};
        jobs[1] = '{count: 16'd0,  seed: 16'h0000, mode: STEADY};
        jobs[2] = '{count: 16'd12, seed: 16'h91e7, mode: SPARSE};
        // Longer than all lane FIFOs plus the output buffer
        jobs[3] = '{count: 16'd14, seed: 16'h5a5a, mode: HELD};
        jobs[4] = '{count: 16'd1,  seed: 16'hc0de, mode: SPARSE};
        jobs[5] = '{count: 16'd9,  seed: 16'h7f10, mode: STEADY};
    endtask

    function automatic int total_packets();
        int sum;
        sum = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            sum += int'(jobs[j].count);
        end
        return sum;
    endfunction

    function automatic logic [LANE_DATA_W-1:0] lane_value(
        input logic [LANE_DATA_W-1:0] job_seed, input int k, input int l);
        return job_seed ^ LANE_DATA_W'(k * 263) ^ LANE_DATA_W'((l << 12) | l);
    endfunction

    // Word w of a lane counts across all jobs in table order
    function automatic logic [LANE_DATA_W-1:0] word_for(input int l, input int w);
        int                     base;
        logic [LANE_DATA_W-1:0] value;
        base  = 0;
        value = '0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            if (w >= base && w < base + int'(jobs[j].count)) begin
                value = lane_value(jobs[j].seed, w - base, l);
            end
            base += int'(jobs[j].count);
        end
        return value;
    endfunction

    function automatic merged_packet_t expected_packet(input int j, input int k);
        merged_packet_t p;
        p       = '0;
        p.valid = 1'b1;
        p.index = COUNT_W'(k);
        p.last  = (k == int'(jobs[j].count) - 1);
        for (int l = 0; l < LANES; l++) begin
            p.lane_data[l] = lane_value(jobs[j].seed, k, l);
        end
        return p;
    endfunction

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic check_packet(input merged_packet_t got, input merged_packet_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: packet %0d got %h expected %h",
                     $time, exp.index, got, exp);
        end
    endtask

    task automatic check_done(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s, done is %b instead of %b", $time, what, got, exp);
        end
    endtask

    task automatic check_credit_count(input string what, input int got,
                                      input int lo, input int hi);
        checks++;
        if (got < lo || got > hi) begin
            errors++;
            $display("ERR %0t: %s is %0d, allowed %0d to %0d", $time, what, got, lo, hi);
        end
    endtask

    // ----------------------------------------------------------------------
    // Lane senders, each with its own credit count
    // ----------------------------------------------------------------------
    always @(posedge ap_clk) begin
        if (areset_generator) begin
            cycle = 0;
            for (int l = 0; l < LANES; l++) begin
                words_sent[l]     = 0;
                sender_credits[l] = FIFO_DEPTH;
                credit_pulses[l]  = 0;
            end
        end else begin
            cycle++;
            for (int l = 0; l < LANES; l++) begin
                if (lane_credit[l]) begin
                    sender_credits[l]++;
                    credit_pulses[l]++;
                    check_credit_count($sformatf("lane %0d sender credits", l),
                                       sender_credits[l], 1, FIFO_DEPTH);
                end
                // Staggered idle cycles keep the lanes out of step
                if (words_sent[l] < words_requested && sender_credits[l] > 0 &&
                    ((cycle + l) % 4) != 3) begin
                    lane_in[l] <= '{valid: 1'b1, data: word_for(l, words_sent[l])};
                    sender_credits[l]--;
                    words_sent[l]++;
                end else begin
                    lane_in[l] <= '0;
                end
            end
        end
    end

    always @(posedge ap_clk) begin
        if (areset_generator) begin
            valid_pulses  = 0;
            config_pulses = 0;
        end else begin
            valid_pulses  += int'(packet_out.valid);
            config_pulses += int'(config_credit);
        end
    end

    // ----------------------------------------------------------------------
    // Job steps
    // ----------------------------------------------------------------------
    task automatic wait_config_credit(input string what);
        bit seen;
        seen = 1'b0;
        for (int c = 0; c < RESPONSE_CYCLES && !seen; c++) begin
            @(posedge ap_clk);
            seen = config_credit;
        end
        if (!seen) begin
            errors++;
            $display("No configuration credit came back while waiting for the %s", what);
        end
    endtask

    task automatic grant_credits(input int cnt, input credit_mode_t mode);
        int given;
        int start;
        given = 0;
        start = packets_seen;
        if (mode == HELD) begin
            repeat (HOLD_CYCLES) @(posedge ap_clk);
            check_credit_count("packets sent without credits", packets_seen - start, 0, 0);
        end
        while (given < cnt) begin
            @(posedge ap_clk);
            if (mode != SPARSE || ($random(seed) & 3) == 0) begin
                out_credit <= 1'b1;
                given++;
                grants_total++;
            end else begin
                out_credit <= 1'b0;
            end
        end
        @(posedge ap_clk);
        out_credit <= 1'b0;
    endtask

    task automatic collect_packets(input int j);
        for (int k = 0; k < int'(jobs[j].count); k++) begin
            do @(posedge ap_clk); while (!packet_out.valid);
            packets_seen++;
            check_packet(packet_out, expected_packet(j, k));
            check_done(done, 1'b0, "done while packets remain");
            check_credit_count("packets against credits", packets_seen, 0, grants_total);
        end
    endtask

    task automatic run_job(input int j);
        int cnt;
        cnt = int'(jobs[j].count);
        @(posedge ap_clk);
        config_in       <= '{valid: 1'b1, packet_count: jobs[j].count};
        words_requested <= words_requested + cnt;
        @(posedge ap_clk);
        config_in <= '0;
        wait_config_credit($sformatf("start of job %0d", j));
        check_done(done, 1'b0, "done after a job was accepted");
        fork
            grant_credits(cnt, jobs[j].mode);
            collect_packets(j);
        join
        for (int c = 0; c < RESPONSE_CYCLES && !done; c++) begin
            @(posedge ap_clk);
        end
        check_done(done, 1'b1, $sformatf("end of job %0d", j));
    endtask

    task automatic run_watchdog();
        int budget;
        budget = total_packets() * CYCLES_PER_PKT + NUM_JOBS * CYCLES_PER_JOB
                 + HOLD_CYCLES + 20;
        #(budget * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the DUT stopped making progress",
                 budget);
        $display("Verification failed");
        $finish;
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int total;
        areset_generator = 1'b1;
        config_in        = '0;
        out_credit       = 1'b0;
        for (int l = 0; l < LANES; l++) begin
            lane_in[l] = '0;
        end
        load_job_table();
        total = total_packets();
        fork
            run_watchdog();
        join_none

        repeat (8) @(posedge ap_clk);
        areset_generator <= 1'b0;
        wait_config_credit("first job after reset");

        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end
        repeat (10) @(posedge ap_clk);

        check_credit_count("configuration credits", config_pulses, NUM_JOBS + 1, NUM_JOBS + 1);
        check_credit_count("packets out", valid_pulses, total, total);
        for (int l = 0; l < LANES; l++) begin
            check_credit_count($sformatf("lane %0d words sent", l), words_sent[l], total, total);
            check_credit_count($sformatf("lane %0d credit pulses", l),
                               credit_pulses[l], total, total);
            check_credit_count($sformatf("lane %0d credits at end", l),
                               sender_credits[l], FIFO_DEPTH, FIFO_DEPTH);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
